/* design/rv_pkg.sv */
package rv_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_mask_t;
  typedef logic [2:0]  funct3_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_CSR    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Write-back source
  typedef enum logic {
    WB_ALU,
    WB_LOAD
  } wb_sel_e;

  // addi x0, x0, 0
  localparam xlen_t NOP_INSTR = 32'h0000_0013;

endpackage

/* design/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile import rv_pkg::*; (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  xlen_t     wdata_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  output xlen_t     rdata_a_o,
  output xlen_t     rdata_b_o
);

  xlen_t regs [32];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 is hardwired to zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

/* design/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu import rv_pkg::*; (
  input  xlen_t   a_i,
  input  xlen_t   b_i,
  input  alu_op_e op_i,
  output xlen_t   res_o
);

  logic [4:0] shamt;

  // Shift amount is the low five bits of B
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  res_o = a_i + b_i;
      ALU_SUB:  res_o = a_i - b_i;
      ALU_SLL:  res_o = a_i << shamt;
      ALU_SLT:  res_o = {31'd0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: res_o = {31'd0, a_i < b_i};
      ALU_XOR:  res_o = a_i ^ b_i;
      ALU_SRL:  res_o = a_i >> shamt;
      ALU_SRA:  res_o = xlen_t'($signed(a_i) >>> shamt);
      ALU_OR:   res_o = a_i | b_i;
      ALU_AND:  res_o = a_i & b_i;
      default:  res_o = '0;
    endcase
  end

endmodule

/* design/rv_decode_stage.sv */
`timescale 1ns/1ps

module rv_decode_stage import rv_pkg::*; #(
  parameter xlen_t PC_RESET = 32'h0000_2000
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  logic      stall_i,
  input  xlen_t     icache_dout_i,
  input  xlen_t     rf_rdata_a_i,
  input  xlen_t     rf_rdata_b_i,
  input  xlen_t     x_alu_res_i,
  input  logic      wb_we_i,
  input  reg_addr_t wb_rd_i,
  input  xlen_t     wb_data_i,
  output logic      icache_re_o,
  output xlen_t     icache_addr_o,
  output reg_addr_t rf_raddr_a_o,
  output reg_addr_t rf_raddr_b_o,
  output logic      x_valid_o,
  output xlen_t     x_pc_o,
  output xlen_t     x_rs1_data_o,
  output xlen_t     x_rs2_data_o,
  output reg_addr_t x_rs1_addr_o,
  output reg_addr_t x_rs2_addr_o,
  output reg_addr_t x_rd_o,
  output xlen_t     x_imm_o,
  output alu_op_e   x_alu_op_o,
  output logic      x_a_pc_o,
  output logic      x_b_imm_o,
  output funct3_t   x_funct3_o,
  output logic      x_reg_we_o,
  output logic      x_load_o,
  output logic      x_store_o,
  output logic      x_csr_we_o
);

  xlen_t   pc_q;
  xlen_t   instr;
  logic    kill;
  opcode_e opc;
  xlen_t   imm;
  alu_op_e alu_op;
  logic    a_pc;
  logic    b_imm;
  logic    reg_we;
  logic    load;
  logic    store;
  logic    csr_we;
  xlen_t   rs1_fwd;
  xlen_t   rs2_fwd;

  // funct3 plus bit 30 to ALU operation; SUB only exists for OP
  function automatic alu_op_e alu_dec(funct3_t f3, logic alt, logic is_op);
    case (f3)
      3'b000:  return (alt && is_op) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // X result first unless it is a load, then WB, then the register file
  function automatic xlen_t fwd(reg_addr_t ra, xlen_t rf_data);
    if ((ra != '0) && x_valid_o && x_reg_we_o && !x_load_o && (x_rd_o == ra)) begin
      return x_alu_res_i;
    end else if (wb_we_i && (wb_rd_i == ra)) begin
      return wb_data_i;
    end
    return rf_data;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Fetch

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= PC_RESET;
    end else if (!stall_i) begin
      pc_q <= pc_q + 32'd4;
    end
  end

  // Replay the previous address while stalled
  assign icache_re_o   = ~stall_i;
  assign icache_addr_o = stall_i ? pc_q - 32'd4 : pc_q;

  // Nothing was fetched yet in the first cycle
  assign kill  = (pc_q == PC_RESET);
  assign instr = kill ? NOP_INSTR : icache_dout_i;
  assign opc   = opcode_e'(instr[6:0]);

  ////////////////////////////////////////////////////////////////////////////
  // Decode

  // LUI reads x0 so that the ALU adds to zero
  assign rf_raddr_a_o = (opc == OPC_LUI) ? '0 : instr[19:15];
  assign rf_raddr_b_o = instr[24:20];

  always_comb begin
    alu_op = ALU_ADD;
    a_pc   = 1'b0;
    b_imm  = 1'b1;
    reg_we = 1'b0;
    load   = 1'b0;
    store  = 1'b0;
    csr_we = 1'b0;
    imm    = {{20{instr[31]}}, instr[31:20]};
    case (opc)
      OPC_OP: begin
        alu_op = alu_dec(instr[14:12], instr[30], 1'b1);
        b_imm  = 1'b0;
        reg_we = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op = alu_dec(instr[14:12], instr[30], 1'b0);
        reg_we = 1'b1;
      end
      OPC_LUI: begin
        imm    = {instr[31:12], 12'd0};
        reg_we = 1'b1;
      end
      OPC_AUIPC: begin
        imm    = {instr[31:12], 12'd0};
        a_pc   = 1'b1;
        reg_we = 1'b1;
      end
      OPC_LOAD: begin
        load   = 1'b1;
        reg_we = 1'b1;
      end
      OPC_STORE: begin
        imm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        store = 1'b1;
      end
      // CSRRW and CSRRWI only
      OPC_CSR: csr_we = (instr[13:12] == 2'b01);
      default: ;
    endcase
  end

  always_comb begin
    rs1_fwd = fwd(rf_raddr_a_o, rf_rdata_a_i);
    rs2_fwd = fwd(rf_raddr_b_o, rf_rdata_b_i);
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/X registers

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_valid_o  <= 1'b0;
      x_reg_we_o <= 1'b0;
      x_load_o   <= 1'b0;
      x_store_o  <= 1'b0;
      x_csr_we_o <= 1'b0;
    end else if (!stall_i) begin
      x_valid_o  <= ~kill;
      x_reg_we_o <= reg_we;
      x_load_o   <= load;
      x_store_o  <= store;
      x_csr_we_o <= csr_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      x_pc_o       <= pc_q - 32'd4;
      x_rs1_data_o <= rs1_fwd;
      x_rs2_data_o <= rs2_fwd;
      x_rs1_addr_o <= rf_raddr_a_o;
      x_rs2_addr_o <= rf_raddr_b_o;
      x_rd_o       <= instr[11:7];
      x_imm_o      <= imm;
      x_alu_op_o   <= alu_op;
      x_a_pc_o     <= a_pc;
      x_b_imm_o    <= b_imm;
      x_funct3_o   <= instr[14:12];
    end
  end

endmodule

/* design/rv_execute_stage.sv */
`timescale 1ns/1ps

module rv_execute_stage import rv_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       stall_i,
  input  logic       x_valid_i,
  input  xlen_t      x_pc_i,
  input  xlen_t      x_rs1_data_i,
  input  xlen_t      x_rs2_data_i,
  input  reg_addr_t  x_rs1_addr_i,
  input  reg_addr_t  x_rs2_addr_i,
  input  reg_addr_t  x_rd_i,
  input  xlen_t      x_imm_i,
  input  alu_op_e    x_alu_op_i,
  input  logic       x_a_pc_i,
  input  logic       x_b_imm_i,
  input  funct3_t    x_funct3_i,
  input  logic       x_reg_we_i,
  input  logic       x_load_i,
  input  logic       x_store_i,
  input  logic       x_csr_we_i,
  input  xlen_t      wb_data_i,
  output xlen_t      x_alu_res_o,
  output logic       dcache_re_o,
  output xlen_t      dcache_addr_o,
  output xlen_t      dcache_din_o,
  output byte_mask_t dcache_we_o,
  output xlen_t      csr_o,
  output xlen_t      w_alu_res_o,
  output reg_addr_t  w_rd_o,
  output logic       w_reg_we_o,
  output logic       w_load_o,
  output funct3_t    w_funct3_o
);

  xlen_t      rs1;
  xlen_t      rs2;
  xlen_t      alu_a;
  xlen_t      alu_b;
  xlen_t      alu_res;
  byte_mask_t st_mask;
  xlen_t      st_data;
  logic       wb_is_load;

  // Load result in WB is only available now
  assign wb_is_load = w_load_o && w_reg_we_o && (w_rd_o != '0);
  assign rs1 = (wb_is_load && (w_rd_o == x_rs1_addr_i)) ? wb_data_i : x_rs1_data_i;
  assign rs2 = (wb_is_load && (w_rd_o == x_rs2_addr_i)) ? wb_data_i : x_rs2_data_i;

  assign alu_a = x_a_pc_i ? x_pc_i : rs1;
  assign alu_b = x_b_imm_i ? x_imm_i : rs2;

  rv_alu u_alu (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .op_i  (x_alu_op_i),
    .res_o (alu_res)
  );

  assign x_alu_res_o = alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // Data port

  // Byte lanes from size and the low address bits
  always_comb begin
    case (x_funct3_i[1:0])
      2'b00: begin
        st_mask = 4'b0001 << alu_res[1:0];
        st_data = {4{rs2[7:0]}};
      end
      2'b01: begin
        st_mask = alu_res[1] ? 4'b1100 : 4'b0011;
        st_data = {2{rs2[15:0]}};
      end
      default: begin
        st_mask = 4'b1111;
        st_data = rs2;
      end
    endcase
  end

  assign dcache_re_o   = ~stall_i && x_valid_i && (x_load_i || x_store_i);
  assign dcache_we_o   = (~stall_i && x_valid_i && x_store_i) ? st_mask : '0;
  assign dcache_din_o  = st_data;
  // Replay the WB load address while stalled
  assign dcache_addr_o = stall_i ? w_alu_res_o : alu_res;

  ////////////////////////////////////////////////////////////////////////////
  // CSR and X/WB registers

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      csr_o      <= '0;
      w_reg_we_o <= 1'b0;
      w_load_o   <= 1'b0;
    end else if (!stall_i) begin
      // CSRRWI takes the zero-extended rs1 field
      if (x_valid_i && x_csr_we_i) begin
        csr_o <= x_funct3_i[2] ? {27'd0, x_rs1_addr_i} : rs1;
      end
      w_reg_we_o <= x_valid_i && x_reg_we_i;
      w_load_o   <= x_valid_i && x_load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      w_alu_res_o <= alu_res;
      w_rd_o      <= x_rd_i;
      w_funct3_o  <= x_funct3_i;
    end
  end

endmodule

/* design/rv_result_stage.sv */
`timescale 1ns/1ps

module rv_result_stage import rv_pkg::*; (
  input  xlen_t     w_alu_res_i,
  input  reg_addr_t w_rd_i,
  input  logic      w_reg_we_i,
  input  logic      w_load_i,
  input  funct3_t   w_funct3_i,
  input  xlen_t     dcache_dout_i,
  input  logic      stall_i,
  output logic      wb_we_o,
  output reg_addr_t wb_rd_o,
  output xlen_t     wb_data_o
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  xlen_t       ld_data;
  wb_sel_e     wb_sel;

  // Lane picked by the low address bits
  assign ld_byte = dcache_dout_i[8*w_alu_res_i[1:0] +: 8];
  assign ld_half = w_alu_res_i[1] ? dcache_dout_i[31:16] : dcache_dout_i[15:0];

  always_comb begin
    case (w_funct3_i)
      3'b000:  ld_data = {{24{ld_byte[7]}}, ld_byte};
      3'b001:  ld_data = {{16{ld_half[15]}}, ld_half};
      3'b100:  ld_data = {24'd0, ld_byte};
      3'b101:  ld_data = {16'd0, ld_half};
      default: ld_data = dcache_dout_i;
    endcase
  end

  assign wb_sel    = w_load_i ? WB_LOAD : WB_ALU;
  assign wb_data_o = (wb_sel == WB_LOAD) ? ld_data : w_alu_res_i;
  assign wb_rd_o   = w_rd_i;
  // No write to x0, none while frozen
  assign wb_we_o   = w_reg_we_i && (w_rd_i != '0) && ~stall_i;

endmodule

/* design/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; #(
  parameter xlen_t PC_RESET = 32'h0000_2000
) (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  xlen_t      icache_dout_i,
  input  xlen_t      dcache_dout_i,
  input  logic       stall_i,
  output logic       icache_re_o,
  output xlen_t      icache_addr_o,
  output logic       dcache_re_o,
  output xlen_t      dcache_addr_o,
  output xlen_t      dcache_din_o,
  output byte_mask_t dcache_we_o,
  output xlen_t      csr_o
);

  // Register file ports
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  xlen_t     rf_rdata_a;
  xlen_t     rf_rdata_b;

  // ID to X
  logic      x_valid;
  xlen_t     x_pc;
  xlen_t     x_rs1_data;
  xlen_t     x_rs2_data;
  reg_addr_t x_rs1_addr;
  reg_addr_t x_rs2_addr;
  reg_addr_t x_rd;
  xlen_t     x_imm;
  alu_op_e   x_alu_op;
  logic      x_a_pc;
  logic      x_b_imm;
  funct3_t   x_funct3;
  logic      x_reg_we;
  logic      x_load;
  logic      x_store;
  logic      x_csr_we;
  xlen_t     x_alu_res;

  // X to WB
  xlen_t     w_alu_res;
  reg_addr_t w_rd;
  logic      w_reg_we;
  logic      w_load;
  funct3_t   w_funct3;

  // Write-back, also forwarded
  logic      wb_we;
  reg_addr_t wb_rd;
  xlen_t     wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // Stages

  rv_decode_stage #(
    .PC_RESET (PC_RESET)
  ) u_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .stall_i       (stall_i),
    .icache_dout_i (icache_dout_i),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .x_alu_res_i   (x_alu_res),
    .wb_we_i       (wb_we),
    .wb_rd_i       (wb_rd),
    .wb_data_i     (wb_data),
    .icache_re_o   (icache_re_o),
    .icache_addr_o (icache_addr_o),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .x_valid_o     (x_valid),
    .x_pc_o        (x_pc),
    .x_rs1_data_o  (x_rs1_data),
    .x_rs2_data_o  (x_rs2_data),
    .x_rs1_addr_o  (x_rs1_addr),
    .x_rs2_addr_o  (x_rs2_addr),
    .x_rd_o        (x_rd),
    .x_imm_o       (x_imm),
    .x_alu_op_o    (x_alu_op),
    .x_a_pc_o      (x_a_pc),
    .x_b_imm_o     (x_b_imm),
    .x_funct3_o    (x_funct3),
    .x_reg_we_o    (x_reg_we),
    .x_load_o      (x_load),
    .x_store_o     (x_store),
    .x_csr_we_o    (x_csr_we)
  );

  rv_regfile u_regfile (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .we_i      (wb_we),
    .waddr_i   (wb_rd),
    .wdata_i   (wb_data),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  rv_execute_stage u_execute (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .stall_i       (stall_i),
    .x_valid_i     (x_valid),
    .x_pc_i        (x_pc),
    .x_rs1_data_i  (x_rs1_data),
    .x_rs2_data_i  (x_rs2_data),
    .x_rs1_addr_i  (x_rs1_addr),
    .x_rs2_addr_i  (x_rs2_addr),
    .x_rd_i        (x_rd),
    .x_imm_i       (x_imm),
    .x_alu_op_i    (x_alu_op),
    .x_a_pc_i      (x_a_pc),
    .x_b_imm_i     (x_b_imm),
    .x_funct3_i    (x_funct3),
    .x_reg_we_i    (x_reg_we),
    .x_load_i      (x_load),
    .x_store_i     (x_store),
    .x_csr_we_i    (x_csr_we),
    .wb_data_i     (wb_data),
    .x_alu_res_o   (x_alu_res),
    .dcache_re_o   (dcache_re_o),
    .dcache_addr_o (dcache_addr_o),
    .dcache_din_o  (dcache_din_o),
    .dcache_we_o   (dcache_we_o),
    .csr_o         (csr_o),
    .w_alu_res_o   (w_alu_res),
    .w_rd_o        (w_rd),
    .w_reg_we_o    (w_reg_we),
    .w_load_o      (w_load),
    .w_funct3_o    (w_funct3)
  );

  rv_result_stage u_result (
    .w_alu_res_i   (w_alu_res),
    .w_rd_i        (w_rd),
    .w_reg_we_i    (w_reg_we),
    .w_load_i      (w_load),
    .w_funct3_i    (w_funct3),
    .dcache_dout_i (dcache_dout_i),
    .stall_i       (stall_i),
    .wb_we_o       (wb_we),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data)
  );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic arst_n_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // Release just after an edge, like every other input
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    arst_n_o = 1'b1;
  end

endmodule

/* bench/rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva import rv_pkg::*; (
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       stall_i,
  input xlen_t      icache_addr_i,
  input logic       dcache_re_i,
  input byte_mask_t dcache_we_i
);

  // No byte may be written while the core is frozen
  a_no_write_in_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i |-> (dcache_we_i == '0))
    else $error("data write enable active during stall");

  // Fetch is replayed at the same address
  a_fetch_replay: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i |-> $stable(icache_addr_i))
    else $error("fetch address moved during stall");

  a_write_has_enable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (dcache_we_i != '0) |-> dcache_re_i)
    else $error("data write without data port enable");

endmodule

bind rv_core_top rv_core_sva u_sva (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .stall_i       (stall_i),
  .icache_addr_i (icache_addr_o),
  .dcache_re_i   (dcache_re_o),
  .dcache_we_i   (dcache_we_o)
);

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top import rv_pkg::*;;

  localparam xlen_t PC_RESET   = 32'h0000_1000;
  localparam int    NUM_RANDOM = 200;
  localparam int    ROM_WORDS  = 256;
  localparam int    TIMEOUT    = 20000;

  logic       clk_i;
  logic       arst_n_i;
  logic       stall_i;
  xlen_t      icache_dout_i;
  xlen_t      dcache_dout_i;
  logic       icache_re_o;
  xlen_t      icache_addr_o;
  logic       dcache_re_o;
  xlen_t      dcache_addr_o;
  xlen_t      dcache_din_o;
  byte_mask_t dcache_we_o;
  xlen_t      csr_o;

  xlen_t      rom [ROM_WORDS];
  xlen_t      dmem [16];
  // ISA model state
  xlen_t      mreg [8];
  logic [7:0] mbyte [64];
  xlen_t      csr_q [$];
  xlen_t      st_addr_q [$];
  xlen_t      st_data_q [$];
  byte_mask_t st_mask_q [$];

  int         csr_idx;
  int         st_idx;
  int         exp_accesses;
  int         accesses;
  xlen_t      exp_pc;
  xlen_t      csr_last;
  logic       out_of_reset_q;
  logic       stall_en;

  tb_clock #(.RESET_CYCLES(8)) u_clock (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  rv_core_top #(
    .PC_RESET (PC_RESET)
  ) dut (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .icache_dout_i (icache_dout_i),
    .dcache_dout_i (dcache_dout_i),
    .stall_i       (stall_i),
    .icache_re_o   (icache_re_o),
    .icache_addr_o (icache_addr_o),
    .dcache_re_o   (dcache_re_o),
    .dcache_addr_o (dcache_addr_o),
    .dcache_din_o  (dcache_din_o),
    .dcache_we_o   (dcache_we_o),
    .csr_o         (csr_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_mask(input string name, input byte_mask_t exp, input byte_mask_t act);
    if (exp !== act) begin
      $display("** Error: %s expected %h actual %h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Encoding and ISA model

  function automatic xlen_t fill_word(int i);
    return (xlen_t'(i) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
  endfunction

  function automatic xlen_t lane_bits(byte_mask_t m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($urandom % 8);
  endfunction

  function automatic xlen_t enc_i(logic [11:0] imm, reg_addr_t rs1, funct3_t f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic xlen_t alu_ref(funct3_t f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic xlen_t model_load(int addr, funct3_t f3);
    case (f3)
      3'b000:  return {{24{mbyte[addr][7]}}, mbyte[addr]};
      3'b001:  return {{16{mbyte[addr+1][7]}}, mbyte[addr+1], mbyte[addr]};
      3'b100:  return {24'd0, mbyte[addr]};
      3'b101:  return {16'd0, mbyte[addr+1], mbyte[addr]};
      default: return {mbyte[addr+3], mbyte[addr+2], mbyte[addr+1], mbyte[addr]};
    endcase
  endfunction

  function automatic void set_reg(reg_addr_t rd, xlen_t val);
    if (rd != '0) begin
      mreg[rd[2:0]] = val;
    end
  endfunction

  function automatic void model_store(int addr, funct3_t f3, xlen_t v);
    int         size;
    xlen_t      d;
    byte_mask_t m;
    size = (f3[1:0] == 2'b00) ? 1 : (f3[1:0] == 2'b01) ? 2 : 4;
    d = '0;
    m = '0;
    for (int k = 0; k < size; k++) begin
      mbyte[addr+k] = v[8*k +: 8];
      d[8*((addr % 4) + k) +: 8] = v[8*k +: 8];
      m[(addr % 4) + k] = 1'b1;
    end
    st_addr_q.push_back(xlen_t'(addr));
    st_data_q.push_back(d);
    st_mask_q.push_back(m);
  endfunction

  // Consecutive equal CSR values cannot be seen on csr_o
  function automatic void model_csr(xlen_t val);
    if (val != csr_last) begin
      csr_q.push_back(val);
      csr_last = val;
    end
  endfunction

  function automatic void gen_program();
    int         n;
    int         kind;
    int         off;
    xlen_t      pc;
    xlen_t      instr;
    xlen_t      w;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    funct3_t    f3;
    logic       alt;
    logic [11:0] imm;
    logic [19:0] imm20;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = NOP_INSTR;
    end
    for (int i = 0; i < 16; i++) begin
      dmem[i] = fill_word(i);
    end
    for (int i = 0; i < 64; i++) begin
      w = fill_word(i / 4);
      mbyte[i] = w[8*(i%4) +: 8];
    end
    for (int i = 0; i < 8; i++) begin
      mreg[i] = '0;
    end
    csr_last     = '0;
    exp_accesses = 0;
    n = 0;
    for (int i = 0; i < NUM_RANDOM; i++) begin
      pc    = PC_RESET + xlen_t'(4 * n);
      kind  = int'($urandom % 10);
      rd    = rand_reg();
      rs1   = rand_reg();
      rs2   = rand_reg();
      f3    = funct3_t'($urandom % 8);
      alt   = 1'($urandom % 2);
      imm   = 12'($urandom);
      imm20 = 20'($urandom);
      if (kind < 3) begin
        if ((f3 != 3'b000) && (f3 != 3'b101)) begin
          alt = 1'b0;
        end
        instr = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
        set_reg(rd, alu_ref(f3, alt, mreg[rs1[2:0]], mreg[rs2[2:0]]));
      end else if (kind < 5) begin
        // Shifts carry only a shift amount and the SRAI bit
        if (f3 == 3'b001 || f3 == 3'b101) begin
          imm = {1'b0, (f3 == 3'b101) && alt, 5'd0, imm[4:0]};
        end
        alt = (f3 == 3'b101) && imm[10];
        instr = enc_i(imm, rs1, f3, rd, 7'b0010011);
        set_reg(rd, alu_ref(f3, alt, mreg[rs1[2:0]], {{20{imm[11]}}, imm}));
      end else if (kind == 5) begin
        instr = {imm20, rd, 7'b0110111};
        set_reg(rd, {imm20, 12'd0});
      end else if (kind == 6) begin
        instr = {imm20, rd, 7'b0010111};
        set_reg(rd, pc + {imm20, 12'd0});
      end else if (kind == 7) begin
        f3  = funct3_t'($urandom % 5);
        f3  = (f3 > 3'd2) ? f3 + 3'd1 : f3;
        off = int'($urandom % 64) & ~((1 << f3[1:0]) - 1);
        instr = enc_i(12'(off), '0, f3, rd, 7'b0000011);
        set_reg(rd, model_load(off, f3));
        exp_accesses++;
      end else if (kind == 8) begin
        f3  = funct3_t'($urandom % 3);
        off = int'($urandom % 64) & ~((1 << f3[1:0]) - 1);
        imm = 12'(off);
        instr = {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'b0100011};
        model_store(off, f3, mreg[rs2[2:0]]);
        exp_accesses++;
      end else if (alt) begin
        // CSRRWI with the immediate in the rs1 field
        instr = enc_i(12'h340, rs1, 3'b101, 5'd0, 7'b1110011);
        model_csr({27'd0, rs1});
      end else begin
        instr = enc_i(12'h340, rs1, 3'b001, 5'd0, 7'b1110011);
        model_csr(mreg[rs1[2:0]]);
      end
      rom[n] = instr;
      n++;
    end
    // Register dump through the CSR
    for (int k = 1; k < 8; k++) begin
      rom[n] = enc_i(12'h340, reg_addr_t'(k), 3'b001, 5'd0, 7'b1110011);
      model_csr(mreg[k]);
      n++;
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory models and stall

  always @(posedge clk_i) begin
    xlen_t a;
    xlen_t idx;
    logic  re;
    a   = icache_addr_o;
    re  = icache_re_o;
    idx = (a - PC_RESET) >> 2;
    #2;
    if (re) begin
      icache_dout_i = (a < PC_RESET || idx >= ROM_WORDS) ? NOP_INSTR : rom[idx[7:0]];
    end
  end

  always @(posedge clk_i) begin
    xlen_t      a;
    xlen_t      d;
    byte_mask_t m;
    a = dcache_addr_o;
    d = dcache_din_o;
    m = dcache_we_o;
    for (int k = 0; k < 4; k++) begin
      if (m[k]) begin
        dmem[a[5:2]][8*k +: 8] = d[8*k +: 8];
      end
    end
    #2;
    dcache_dout_i = dmem[a[5:2]];
  end

  always @(posedge clk_i) begin
    #2;
    stall_i = stall_en && (($urandom % 100) < 20);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitors, sampled mid-cycle

  always @(negedge clk_i) begin
    if (!arst_n_i || !out_of_reset_q) begin
      check_mask("reset store mask", '0, dcache_we_o);
      check_word("reset csr", '0, csr_o);
    end
    out_of_reset_q = arst_n_i;
    if (arst_n_i) begin
      if (icache_re_o !== !stall_i) begin
        fail_run("fetch enable does not follow the stall input");
      end
      if (!stall_i) begin
        check_word("fetch address", exp_pc, icache_addr_o);
        exp_pc = exp_pc + 32'd4;
      end
      // Each load or store uses the data port in one unstalled cycle
      if (dcache_re_o === 1'b1) begin
        if (stall_i) begin
          fail_run("data port enabled during a stall");
        end
        accesses++;
      end
      if (csr_o !== csr_last) begin
        if (csr_idx >= csr_q.size()) begin
          fail_run("csr_o changed after the last CSR write of the program");
        end
        check_word($sformatf("csr write %0d", csr_idx), csr_q[csr_idx], csr_o);
        csr_idx++;
        csr_last = csr_o;
      end
      if (dcache_we_o != '0) begin
        if (st_idx >= st_mask_q.size()) begin
          fail_run("a store appeared that the program does not contain");
        end
        check_word($sformatf("store %0d address", st_idx), st_addr_q[st_idx], dcache_addr_o);
        check_mask($sformatf("store %0d mask", st_idx), st_mask_q[st_idx], dcache_we_o);
        check_word($sformatf("store %0d data", st_idx), st_data_q[st_idx],
                   dcache_din_o & lane_bits(dcache_we_o));
        st_idx++;
      end
    end
  end

  initial begin
    int cyc;
    stall_i        = 1'b0;
    icache_dout_i  = NOP_INSTR;
    dcache_dout_i  = '0;
    stall_en       = 1'b0;
    out_of_reset_q = 1'b0;
    csr_idx        = 0;
    st_idx         = 0;
    accesses       = 0;
    exp_pc         = PC_RESET;
    void'($urandom(32'h7cd7_4f02));
    gen_program();
    // Monitor compares against csr_o starting from its reset value
    csr_last = '0;
    for (cyc = 0; cyc < 100 && arst_n_i !== 1'b1; cyc++) begin
      @(posedge clk_i);
    end
    if (arst_n_i !== 1'b1) begin
      fail_run("reset was never released");
    end else begin
      @(posedge clk_i);
      stall_en = 1'b1;
      for (cyc = 0; cyc < TIMEOUT &&
           !(csr_idx == csr_q.size() && st_idx == st_mask_q.size()); cyc++) begin
        @(posedge clk_i);
      end
      if (!(csr_idx == csr_q.size() && st_idx == st_mask_q.size())) begin
        fail_run("the core never produced all CSR writes and stores of the program");
      end else begin
        // Give stray writes a chance to show up
        repeat (10) @(posedge clk_i);
        if (accesses == exp_accesses) begin
          $display("RESULT: PASS");
          $finish;
        end else begin
          check_word("data port accesses", xlen_t'(exp_accesses), xlen_t'(accesses));
        end
      end
    end
  end

endmodule

/* build.f */
design/rv_pkg.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_decode_stage.sv
design/rv_execute_stage.sv
design/rv_result_stage.sv
design/rv_core_top.sv
bench/tb_clock.sv
bench/rv_core_sva.sv
bench/tb_top.sv

/* run.sh */
#!/bin/sh
# Build the bench with Verilator and run it; pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f build.f --top-module tb_top -o tb_sim \
  && ./obj_dir/tb_sim | grep -F "RESULT: PASS" \
  || { echo "Simulation did not pass"; exit 1; }
